//--- verilog/display_pkg.sv
//==========================================================================
// Display controller shared definitions
// Raster timing, burst geometry, framebuffer location and the types
// passed between the timing, FIFO and fetch blocks
//==========================================================================
`default_nettype none

package display_pkg;

	// Horizontal phases in pixels, visible first
	localparam int H_VISIBLE = 16;
	localparam int H_FRONT = 2;
	localparam int H_SYNC = 3;
	localparam int H_BACK = 3;
	localparam int H_TOTAL = H_VISIBLE + H_FRONT + H_SYNC + H_BACK;

	// Vertical phases in lines
	localparam int V_VISIBLE = 8;
	localparam int V_FRONT = 1;
	localparam int V_SYNC = 2;
	localparam int V_BACK = 1;
	localparam int V_TOTAL = V_VISIBLE + V_FRONT + V_SYNC + V_BACK;

	// Raster counter widths
	localparam int H_COUNT_WIDTH = $clog2(H_TOTAL);
	localparam int V_COUNT_WIDTH = $clog2(V_TOTAL);

	// System clocks per pixel
	localparam int PIXEL_DIVIDE = 2;
	localparam int DIVIDE_WIDTH = $clog2(PIXEL_DIVIDE);

	// Visible pixels per frame, one memory word each
	localparam int TOTAL_PIXELS = H_VISIBLE * V_VISIBLE;
	// At least 16 bits, wider for large rasters such as 640x480
	localparam int PIXEL_COUNT_WIDTH = ($clog2(TOTAL_PIXELS + 1) > 16) ?
		$clog2(TOTAL_PIXELS + 1) : 16;

	// Read burst and FIFO geometry
	localparam int BURST_LENGTH = 8;
	localparam int BEAT_WIDTH = $clog2(BURST_LENGTH);
	localparam int FIFO_DEPTH = 32;
	localparam int FIFO_ADDR_WIDTH = $clog2(FIFO_DEPTH);

	typedef logic [31:0] addr_t;
	typedef logic [31:0] word_t;
	typedef logic [7:0] color_t;
	typedef logic [PIXEL_COUNT_WIDTH-1:0] pixel_count_t;

	// Byte address of pixel 0, pixel k sits 4k bytes above
	localparam addr_t FB_BASE_ADDR = 32'h1000_0000;

	// Memory word layout is blue 31:24, green 23:16, red 15:8
	typedef struct packed {
		color_t blue;
		color_t green;
		color_t red;
	} rgb_t;

	// Sync pulses are active high
	typedef struct packed {
		logic hsync;
		logic vsync;
		logic blank_n;
	} video_sync_t;

	// Read address request, len is beats minus one
	typedef struct packed {
		addr_t addr;
		logic [7:0] len;
	} ar_req_t;

	typedef enum logic [1:0] {
		WAIT_FRAME,
		WAIT_SPACE,
		ISSUE_ADDR,
		BURST
	} fetch_state_t;

endpackage

`default_nettype wire

//--- verilog/display_timing.sv
//==========================================================================
// Video timing generator
// Divides the clock down to the pixel rate, walks the raster and
// produces registered sync, blanking, visible region and frame start
//==========================================================================
`timescale 1ns/1ns
`default_nettype none

module display_timing import display_pkg::*; (
	input  logic        clk,
	input  logic        reset,
	output logic        pixel_enable,
	output logic        in_visible,
	output logic        new_frame,
	output video_sync_t sync
);

	logic [DIVIDE_WIDTH-1:0] div_count;
	logic [H_COUNT_WIDTH-1:0] h_count;
	logic [V_COUNT_WIDTH-1:0] v_count;
	logic h_visible;
	logic v_visible;
	logic h_sync_zone;
	logic v_sync_zone;
	logic h_last;
	logic v_last;

	// One enable every PIXEL_DIVIDE clocks
	assign pixel_enable = div_count == DIVIDE_WIDTH'(PIXEL_DIVIDE - 1);

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
			div_count <= '0;
		else if (pixel_enable)
			div_count <= '0;
		else
			div_count <= div_count + 1'b1;
	end

	// Raster position decode
	assign h_visible = h_count < H_COUNT_WIDTH'(H_VISIBLE);
	assign v_visible = v_count < V_COUNT_WIDTH'(V_VISIBLE);
	assign h_sync_zone = (h_count >= H_COUNT_WIDTH'(H_VISIBLE + H_FRONT))
		&& (h_count < H_COUNT_WIDTH'(H_VISIBLE + H_FRONT + H_SYNC));
	assign v_sync_zone = (v_count >= V_COUNT_WIDTH'(V_VISIBLE + V_FRONT))
		&& (v_count < V_COUNT_WIDTH'(V_VISIBLE + V_FRONT + V_SYNC));
	assign h_last = h_count == H_COUNT_WIDTH'(H_TOTAL - 1);
	assign v_last = v_count == V_COUNT_WIDTH'(V_TOTAL - 1);

	// Counters start on the first visible pixel
	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			h_count <= '0;
			v_count <= '0;
		end
		else if (pixel_enable)
		begin
			if (h_last)
			begin
				h_count <= '0;
				// Line wrap steps the vertical counter
				if (v_last)
					v_count <= '0;
				else
					v_count <= v_count + 1'b1;
			end
			else
				h_count <= h_count + 1'b1;
		end
	end

	// Outputs follow the counters one clock later
	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			in_visible <= 1'b0;
			sync <= '0;
			new_frame <= 1'b0;
		end
		else
		begin
			in_visible <= h_visible && v_visible;
			sync.hsync <= h_sync_zone;
			sync.vsync <= v_sync_zone;
			sync.blank_n <= h_visible && v_visible;
			// Pulse as the counters land on the first pixel of vsync
			new_frame <= pixel_enable && h_last
				&& (v_count == V_COUNT_WIDTH'(V_VISIBLE + V_FRONT - 1));
		end
	end

endmodule

`default_nettype wire

//--- verilog/pixel_fifo.sv
//==========================================================================
// Pixel FIFO
// Circular word buffer between the fetch engine and the DAC output,
// with a frame flush and a flag that promises room for one burst
//==========================================================================
`timescale 1ns/1ns
`default_nettype none

module pixel_fifo import display_pkg::*; (
	input  logic  clk,
	input  logic  reset,
	input  logic  flush,
	input  logic  write,
	input  word_t write_data,
	input  logic  read,
	output word_t read_data,
	output logic  empty,
	output logic  almost_empty
);

	word_t mem [FIFO_DEPTH];
	logic [FIFO_ADDR_WIDTH-1:0] wr_ptr;
	logic [FIFO_ADDR_WIDTH-1:0] rd_ptr;
	logic [FIFO_ADDR_WIDTH:0] count;
	logic [FIFO_ADDR_WIDTH+1:0] fill_next;
	logic push;
	logic pop;

	// Flush beats a write on the same edge
	assign push = write && !flush;
	assign pop = read && !empty;

	assign empty = count == '0;
	assign read_data = mem[rd_ptr];

	// Counts a write already on the bus, so a burst that is just ending
	// is charged before the next request goes out
	assign fill_next = {1'b0, count} + {{(FIFO_ADDR_WIDTH + 1){1'b0}}, write};
	assign almost_empty = fill_next <= (FIFO_ADDR_WIDTH + 2)'(FIFO_DEPTH - BURST_LENGTH);

	always_ff @(posedge clk)
	begin
		if (push)
			mem[wr_ptr] <= write_data;
	end

	// Depth is a power of two, pointers wrap on their own
	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end
		else if (flush)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end
		else
		begin
			if (push)
				wr_ptr <= wr_ptr + 1'b1;
			if (pop)
				rd_ptr <= rd_ptr + 1'b1;
			// Simultaneous push and pop leave the count alone
			if (push && !pop)
				count <= count + 1'b1;
			else if (!push && pop)
				count <= count - 1'b1;
		end
	end

endmodule

`default_nettype wire

//--- verilog/frame_fetch.sv
//==========================================================================
// Frame fetch engine
// Read burst master that walks the framebuffer from its base each frame
// and requests a burst whenever the pixel FIFO can take all of it
//==========================================================================
`timescale 1ns/1ns
`default_nettype none

module frame_fetch import display_pkg::*; (
	input  logic    clk,
	input  logic    reset,
	input  logic    new_frame,
	input  logic    almost_empty,
	output ar_req_t ar,
	output logic    ar_valid,
	input  logic    ar_ready,
	input  logic    r_valid,
	output logic    r_ready
);

	fetch_state_t state;
	addr_t burst_addr;
	pixel_count_t fetched;
	logic [BEAT_WIDTH-1:0] beat_count;
	logic restart_pending;
	logic last_beat;

	assign last_beat = r_valid && (beat_count == BEAT_WIDTH'(BURST_LENGTH - 1));

	// Single outstanding burst with room reserved, so data is never refused
	assign r_ready = 1'b1;
	assign ar_valid = state == ISSUE_ADDR;
	assign ar.addr = burst_addr;
	assign ar.len = 8'(BURST_LENGTH - 1);

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			state <= WAIT_FRAME;
			burst_addr <= FB_BASE_ADDR;
			fetched <= '0;
			beat_count <= '0;
			restart_pending <= 1'b0;
		end
		else
		begin
			case (state)
				WAIT_FRAME, WAIT_SPACE:
				begin
					// FIFO is flushed on this edge, so there is room
					if (new_frame)
					begin
						state <= ISSUE_ADDR;
						burst_addr <= FB_BASE_ADDR;
						fetched <= '0;
					end
					else if (state == WAIT_SPACE && almost_empty)
						state <= ISSUE_ADDR;
				end

				ISSUE_ADDR:
				begin
					// Request must hold still, so a frame start is deferred
					if (new_frame)
						restart_pending <= 1'b1;
					if (ar_ready)
						state <= BURST;
				end

				BURST:
				begin
					if (new_frame)
						restart_pending <= 1'b1;
					if (r_valid)
						beat_count <= beat_count + 1'b1;
					if (last_beat)
					begin
						beat_count <= '0;
						if (restart_pending || new_frame)
						begin
							// Late burst from the last frame, start over at the base
							restart_pending <= 1'b0;
							burst_addr <= FB_BASE_ADDR;
							fetched <= '0;
							state <= almost_empty ? ISSUE_ADDR : WAIT_SPACE;
						end
						else if (fetched == pixel_count_t'(TOTAL_PIXELS - BURST_LENGTH))
							state <= WAIT_FRAME;
						else
						begin
							// Next burst is one burst of words further on
							burst_addr <= burst_addr + addr_t'(BURST_LENGTH * 4);
							fetched <= fetched + pixel_count_t'(BURST_LENGTH);
							state <= almost_empty ? ISSUE_ADDR : WAIT_SPACE;
						end
					end
				end

				default:
					state <= WAIT_FRAME;
			endcase
		end
	end

endmodule

`default_nettype wire

//--- verilog/display_controller.sv
//==========================================================================
// Scan-out display controller
// Fetches the framebuffer over the read channel, buffers it and drives
// registered pixels, sync and an under-run flag to the video DAC
//==========================================================================
`timescale 1ns/1ns
`default_nettype none

module display_controller import display_pkg::*; (
	input  logic        clk,
	input  logic        reset,
	output ar_req_t     ar,
	output logic        ar_valid,
	input  logic        ar_ready,
	input  logic        r_valid,
	output logic        r_ready,
	input  word_t       r_data,
	output rgb_t        rgb,
	output video_sync_t sync,
	output logic        pixel_clk,
	output logic        underrun
);

	logic pixel_enable;
	logic in_visible;
	logic new_frame;
	video_sync_t timing_sync;
	word_t fifo_data;
	logic fifo_empty;
	logic fifo_almost_empty;
	logic fifo_write;
	logic fifo_read;
	logic starved;
	logic frame_active;
	rgb_t pixel_color;

	display_timing u_timing (
		.clk          (clk),
		.reset        (reset),
		.pixel_enable (pixel_enable),
		.in_visible   (in_visible),
		.new_frame    (new_frame),
		.sync         (timing_sync)
	);

	// Every accepted beat lands in the FIFO
	assign fifo_write = r_valid && r_ready;
	// Pop one word per visible pixel while data is there
	assign fifo_read = pixel_enable && in_visible && !fifo_empty;

	pixel_fifo u_fifo (
		.clk          (clk),
		.reset        (reset),
		.flush        (new_frame),
		.write        (fifo_write),
		.write_data   (r_data),
		.read         (fifo_read),
		.read_data    (fifo_data),
		.empty        (fifo_empty),
		.almost_empty (fifo_almost_empty)
	);

	frame_fetch u_fetch (
		.clk          (clk),
		.reset        (reset),
		.new_frame    (new_frame),
		.almost_empty (fifo_almost_empty),
		.ar           (ar),
		.ar_valid     (ar_valid),
		.ar_ready     (ar_ready),
		.r_valid      (r_valid),
		.r_ready      (r_ready)
	);

	// Color channels from the word, low byte unused
	assign pixel_color.blue = fifo_data[31:24];
	assign pixel_color.green = fifo_data[23:16];
	assign pixel_color.red = fifo_data[15:8];

	// Visible pixel with nothing buffered, only counted once fetching began
	assign starved = pixel_enable && in_visible && fifo_empty && frame_active;
	assign pixel_clk = pixel_enable;

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			rgb <= '0;
			sync <= '0;
			underrun <= 1'b0;
			frame_active <= 1'b0;
		end
		else
		begin
			if (new_frame)
				frame_active <= 1'b1;
			underrun <= starved;
			// Pixel and its sync leave together, black when blank or starved
			if (pixel_enable)
			begin
				rgb <= fifo_read ? pixel_color : '0;
				sync <= timing_sync;
			end
		end
	end

endmodule

`default_nettype wire

//--- dv/display_checker.sv
//==========================================================================
// Display controller assertions
// Read channel handshake, burst length and pixel FIFO occupancy
//==========================================================================
`timescale 1ns/1ns
`default_nettype none

module display_checker import display_pkg::*; (
	input logic    clk,
	input logic    reset,
	input ar_req_t ar,
	input logic    ar_valid,
	input logic    ar_ready,
	input logic    r_valid,
	input logic    new_frame,
	input logic    fifo_write,
	input logic    fifo_read
);

	int occupancy;
	int beats;

	// Occupancy rebuilt from the FIFO strobes, flush empties it
	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
			occupancy <= 0;
		else if (new_frame)
			occupancy <= 0;
		else
			occupancy <= occupancy + int'(fifo_write) - int'(fifo_read);
	end

	// Beats of the current burst, full count while none is outstanding
	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
			beats <= BURST_LENGTH;
		else if (ar_valid && ar_ready)
			beats <= 0;
		else if (r_valid)
			beats <= beats + 1;
	end

	// Waiting request holds its address and length
	hold_request: assert property (@(posedge clk) disable iff (reset)
		ar_valid && !ar_ready |=> ar_valid && $stable(ar))
		else $error("read request changed or dropped before acceptance");

	// Accepted burst always fits in the FIFO
	room_for_burst: assert property (@(posedge clk) disable iff (reset)
		ar_valid && ar_ready |-> occupancy <= FIFO_DEPTH - BURST_LENGTH)
		else $error("burst requested without room for all of its beats");

	// Next request only once the previous burst delivered all its beats
	burst_beats: assert property (@(posedge clk) disable iff (reset)
		ar_valid |-> beats == BURST_LENGTH)
		else $error("read request raised before the previous burst completed");

	no_overflow: assert property (@(posedge clk) disable iff (reset)
		fifo_write && !fifo_read && !new_frame |-> occupancy < FIFO_DEPTH)
		else $error("pixel FIFO written while full");

endmodule

bind display_controller display_checker u_checker (
	.clk        (clk),
	.reset      (reset),
	.ar         (ar),
	.ar_valid   (ar_valid),
	.ar_ready   (ar_ready),
	.r_valid    (r_valid),
	.new_frame  (new_frame),
	.fifo_write (fifo_write),
	.fifo_read  (fifo_read)
);

`default_nettype wire

//--- dv/display_tb.sv
//==========================================================================
// Display controller testbench
// Random-latency memory responder, raster and pixel model, a stall
// frame that forces under-runs, and a watchdog
//==========================================================================
`timescale 1ns/1ns
`default_nettype none

module display_tb import display_pkg::*; ();

	localparam int NUM_FRAMES = 6;
	localparam int STALL_FRAME = 2;
	localparam int CLOCK_PERIOD = 4;
	localparam int FRAME_CLOCKS = H_TOTAL * V_TOTAL * PIXEL_DIVIDE;
	// Frames to check, the partial first frame and some slack
	localparam int TIMEOUT_NS = (NUM_FRAMES + 2) * FRAME_CLOCKS * CLOCK_PERIOD;

	logic clk;
	logic reset;
	ar_req_t ar;
	logic ar_valid;
	logic ar_ready;
	logic r_valid;
	logic r_ready;
	word_t r_data;
	rgb_t rgb;
	video_sync_t sync;
	logic pixel_clk;
	logic underrun;

	integer seed;
	int value_errors = 0;
	int other_errors = 0;
	// Responder state
	logic stall_mode = 1'b0;
	logic short_frame_ok = 1'b0;
	int burst_index = 0;
	// Raster and pixel model state
	logic synced = 1'b0;
	logic stall_frame = 1'b0;
	logic underrun_pending = 1'b0;
	logic last_vsync = 1'b0;
	logic last_hsync = 1'b0;
	int frames_done = 0;
	int visible_pixels = 0;
	int word_index = 0;
	int vsync_pixels = 0;
	int hsync_pulses = 0;
	int hsync_run = 0;
	int frame_underruns = 0;

	display_controller u_dut (
		.clk       (clk),
		.reset     (reset),
		.ar        (ar),
		.ar_valid  (ar_valid),
		.ar_ready  (ar_ready),
		.r_valid   (r_valid),
		.r_ready   (r_ready),
		.r_data    (r_data),
		.rgb       (rgb),
		.sync      (sync),
		.pixel_clk (pixel_clk),
		.underrun  (underrun)
	);

	initial
	begin
		clk = 1'b0;
		forever #(CLOCK_PERIOD / 2) clk = ~clk;
	end

	// Memory content, address scrambled with a constant
	function automatic word_t memory_word(input addr_t addr);
		return (addr * 32'h9E37_79B9) ^ 32'hC3A5_5A3C;
	endfunction

	// Pixel k is word k of the framebuffer, low byte dropped
	function automatic rgb_t expected_pixel(input int k);
		word_t w;
		w = memory_word(FB_BASE_ADDR + addr_t'(4 * k));
		return {w[31:24], w[23:16], w[15:8]};
	endfunction

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] expected);
		if (got !== expected)
		begin
			value_errors++;
			$display("FAIL %s: got 0x%0h expected 0x%0h at %0t ns", name, got, expected, $time);
		end
	endtask

	task automatic report_problem(input string message);
		other_errors++;
		$display("ERROR: %s at %0t ns", message, $time);
	endtask

	// One burst at a time, address checked against the frame walk
	task automatic serve_memory();
		addr_t addr;
		int delay;
		int gap;
		int beat;
		forever
		begin
			@(negedge clk);
			ar_ready = ($random(seed) & 3) != 0;
			if (ar_valid && ar_ready)
			begin
				addr = ar.addr;
				check_value("ar.len", 32'(ar.len), BURST_LENGTH - 1);
				// Base address starts a frame, early only after the stall
				if (addr == FB_BASE_ADDR)
				begin
					if (burst_index != 0 && !short_frame_ok)
						report_problem("fetch restarted at the base before finishing a frame");
					burst_index = 0;
				end
				check_value("ar.addr", addr, FB_BASE_ADDR + addr_t'(32 * burst_index));
				burst_index = (burst_index + 1) % (TOTAL_PIXELS / BURST_LENGTH);
				if (stall_mode)
					delay = 24 + ($random(seed) & 15);
				else
					delay = $random(seed) & 3;
				@(negedge clk);
				ar_ready = 1'b0;
				repeat (delay) @(negedge clk);
				for (beat = 0; beat < BURST_LENGTH; beat++)
				begin
					r_valid = 1'b1;
					r_data = memory_word(addr + addr_t'(4 * beat));
					@(negedge clk);
					check_value("r_ready", 32'(r_ready), 1);
					r_valid = 1'b0;
					gap = stall_mode ? ($random(seed) & 3) : ($random(seed) & 1);
					repeat (gap) @(negedge clk);
				end
			end
		end
	endtask

	task automatic close_frame();
		check_value("sync.blank_n pixels", visible_pixels, TOTAL_PIXELS);
		check_value("sync.vsync pixels", vsync_pixels, V_SYNC * H_TOTAL);
		check_value("sync.hsync pulses", hsync_pulses, V_TOTAL);
		if (stall_frame && frame_underruns == 0)
			report_problem("memory stall frame ended without an under-run");
		else if (!stall_frame && frame_underruns != 0)
			report_problem($sformatf("%0d under-runs in frame %0d with normal memory",
				frame_underruns, frames_done));
		frames_done++;
	endtask

	task automatic start_frame();
		if (synced)
			close_frame();
		synced = 1'b1;
		visible_pixels = 0;
		word_index = 0;
		vsync_pixels = 0;
		hsync_pulses = 0;
		frame_underruns = 0;
		stall_frame = frames_done == STALL_FRAME;
		// Stall frame may be cut short, its successor restarts at the base
		short_frame_ok = stall_frame || frames_done == STALL_FRAME + 1;
		// Slow memory for the first half of this frame
		if (stall_frame)
			stall_mode <= 1'b1;
	endtask

	// One DAC pixel, sync shape and color against the model
	task automatic sample_pixel();
		if (sync.vsync && !last_vsync)
			start_frame();
		last_vsync = sync.vsync;
		if (synced)
		begin
			if (sync.vsync)
				vsync_pixels++;
			if (sync.hsync)
				hsync_run++;
			else if (last_hsync)
			begin
				check_value("sync.hsync width", hsync_run, H_SYNC);
				hsync_pulses++;
				hsync_run = 0;
			end
		end
		last_hsync = sync.hsync;
		if (!sync.blank_n)
			check_value("rgb", 32'(rgb), 0);
		else if (synced)
		begin
			visible_pixels++;
			// Starved pixel is black and consumes no word
			if (underrun_pending)
			begin
				frame_underruns++;
				check_value("rgb", 32'(rgb), 0);
			end
			else
			begin
				check_value("rgb", 32'(rgb), 32'(expected_pixel(word_index)));
				word_index++;
			end
			if (stall_frame && visible_pixels == TOTAL_PIXELS / 2)
				stall_mode <= 1'b0;
		end
		underrun_pending = 1'b0;
	endtask

	// DAC outputs are settled while pixel_clk is high
	always @(negedge clk)
	begin
		if (!reset)
		begin
			// underrun pulses in the clock before its pixel is sampled
			if (underrun)
			begin
				underrun_pending = 1'b1;
				// No fetch has started before the first frame
				if (!synced)
					report_problem("under-run reported before the first frame started");
			end
			if (pixel_clk)
				sample_pixel();
		end
	end

	initial
	begin
		@(negedge reset);
		serve_memory();
	end

	initial
	begin
		seed = 5670;
		reset = 1'b1;
		ar_ready = 1'b0;
		r_valid = 1'b0;
		r_data = '0;
		repeat (3) @(negedge clk);
		reset = 1'b0;
		wait (frames_done == NUM_FRAMES);
		@(negedge clk);
		$display("errors: %0d value mismatches, %0d other failures", value_errors, other_errors);
		if (value_errors == 0 && other_errors == 0)
			$display("** PASS **");
		else
			$display("** FAIL **");
		$finish;
	end

	initial
	begin
		#(TIMEOUT_NS);
		other_errors++;
		$display("Watchdog expired after %0d ns with %0d of %0d frames checked",
			TIMEOUT_NS, frames_done, NUM_FRAMES);
		$display("errors: %0d value mismatches, %0d other failures", value_errors, other_errors);
		$display("** FAIL **");
		$finish;
	end

endmodule

`default_nettype wire

//--- display_controller.f
verilog/display_pkg.sv
verilog/display_timing.sv
verilog/pixel_fifo.sv
verilog/frame_fetch.sv
verilog/display_controller.sv
dv/display_checker.sv
dv/display_tb.sv

//--- Makefile
SIM      = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = display_tb
FILELIST = display_controller.f
OBJ_DIR  = obj_dir
LOG      = sim.log

.PHONY: sim clean

sim:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "\*\* FAIL \*\*" $(LOG); then \
		echo "Simulation failed"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
